// ==== files.f ====
+incdir+src
+incdir+testbench
src/board_pkg.sv
src/wb_map_pkg.sv
src/candidate_if.sv
src/board_features.sv
src/placement_search.sv
src/best_move_tracker.sv
src/wb_board_regs.sv
src/tetris_ai_top.sv
testbench/tb_tetris_ai.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only -Wall --timing
TOP       := tb_tetris_ai
FILELIST  := files.f
LOG       := sim.log
PASS_MSG  := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

// ==== testbench/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// occupancy grid g[row][col], row 0 at the bottom of the 4x4 box
function automatic logic [3:0][3:0] rotated_cells(input int kind, input int rot);
    logic [15:0]     base;
    logic [3:0][3:0] g;
    logic [3:0][3:0] t;
    int              min_r;
    int              min_c;
    case (kind)
        1: base = 16'h0033;
        2: base = 16'h0027;
        3: base = 16'h0063;
        4: base = 16'h0036;
        5: base = 16'h0017;
        6: base = 16'h0047;
        default: base = 16'h000f;
    endcase
    g = base;
    // each quarter turn moves cell (r, c) to (3 - c, r)
    for (int k = 0; k < rot; k++) begin
        t = '0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (g[r][c]) begin
                    t[3 - c][r] = 1'b1;
                end
            end
        end
        g = t;
    end
    min_r = 4;
    min_c = 4;
    for (int r = 0; r < 4; r++) begin
        for (int c = 0; c < 4; c++) begin
            if (g[r][c] && r < min_r) begin
                min_r = r;
            end
            if (g[r][c] && c < min_c) begin
                min_c = c;
            end
        end
    end
    // push the shape against the bottom left corner
    t = '0;
    for (int r = 0; r < 4; r++) begin
        for (int c = 0; c < 4; c++) begin
            if (g[r][c]) begin
                t[r - min_r][c - min_c] = 1'b1;
            end
        end
    end
    return t;
endfunction

// true when the piece at this base row overlaps the stack or the floor
function automatic bit collides(input board_t b, input logic [3:0][3:0] g,
                                input int col, input int base);
    for (int r = 0; r < 4; r++) begin
        for (int c = 0; c < 4; c++) begin
            if (g[r][c]) begin
                if (base + r < 0) begin
                    return 1'b1;
                end
                if (b[base + r][col + c]) begin
                    return 1'b1;
                end
            end
        end
    end
    return 1'b0;
endfunction

task automatic measure_board(input board_t b, output int lines, output int bump,
                             output int heights, output int holes);
    int h [`BOARD_COLS];
    lines   = 0;
    bump    = 0;
    heights = 0;
    holes   = 0;
    for (int y = 0; y < `BOARD_ROWS; y++) begin
        if (b[y] == {`BOARD_COLS{1'b1}}) begin
            lines++;
        end
    end
    for (int c = 0; c < `BOARD_COLS; c++) begin
        h[c] = 0;
        for (int y = 0; y < `BOARD_ROWS; y++) begin
            if (b[y][c]) begin
                h[c] = y + 1;
            end
        end
        heights += h[c];
        for (int y = 0; y < h[c]; y++) begin
            if (!b[y][c]) begin
                holes++;
            end
        end
    end
    for (int c = 1; c < `BOARD_COLS; c++) begin
        bump += (h[c] > h[c-1]) ? h[c] - h[c-1] : h[c-1] - h[c];
    end
endtask

// lines first, then bumpiness, total height and holes
function automatic bit beats_best(input int l, input int bu, input int h, input int ho,
                                  input int bl, input int bb, input int bh, input int bo);
    if (l != bl) begin
        return l > bl;
    end else if (bu != bb) begin
        return bu < bb;
    end else if (h != bh) begin
        return h < bh;
    end
    return ho < bo;
endfunction

task automatic choose_move(input board_t b, input int kind, output bit found,
                           output int best_col, output int best_rot, output int best_lines);
    logic [3:0][3:0] g;
    board_t          m;
    bit              side;
    int              base;
    int              l;
    int              bu;
    int              h;
    int              ho;
    int              bb;
    int              bh;
    int              bo;
    found      = 1'b0;
    best_col   = 0;
    best_rot   = 0;
    best_lines = 0;
    bb = 255;
    bh = 255;
    bo = 255;
    for (int rot = 0; rot < 4; rot++) begin
        g = rotated_cells(kind, rot);
        for (int col = 0; col < `BOARD_COLS; col++) begin
            side = 1'b0;
            for (int r = 0; r < 4; r++) begin
                for (int c = 0; c < 4; c++) begin
                    if (g[r][c] && col + c >= `BOARD_COLS) begin
                        side = 1'b1;
                    end
                end
            end
            base = `BOARD_ROWS - 4;
            if (!side && !collides(b, g, col, base)) begin
                while (!collides(b, g, col, base - 1)) begin
                    base--;
                end
                m = b;
                for (int r = 0; r < 4; r++) begin
                    for (int c = 0; c < 4; c++) begin
                        if (g[r][c]) begin
                            m[base + r][col + c] = 1'b1;
                        end
                    end
                end
                measure_board(m, l, bu, h, ho);
                if (beats_best(l, bu, h, ho, best_lines, bb, bh, bo)) begin
                    found      = 1'b1;
                    best_col   = col;
                    best_rot   = rot;
                    best_lines = l;
                    bb = bu;
                    bh = h;
                    bo = ho;
                end
            end
        end
    end
endtask

`endif

// ==== testbench/tb_tetris_ai.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "tetris_ai_settings.svh"

module tb_tetris_ai;
    import board_pkg::*;
    import wb_map_pkg::*;

    localparam int RANDOM_BOARDS = 16;
    localparam int SEARCHES      = RANDOM_BOARDS + 4;
    // placements per search times worst cycles per placement plus bus traffic margin
    localparam int WATCHDOG_NS   = SEARCHES * 40 * 18 * 10 + 60_000;
    localparam int POLL_LIMIT    = 400;

    logic                  clk;
    logic                  rst;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [`WB_ADDR_W-1:0] wb_adr;
    logic [`WB_DATA_W-1:0] wb_dat_w;
    logic [`WB_DATA_W-1:0] wb_dat_r;
    logic                  wb_ack;
    logic [31:0]           rng;
    board_t                tb_board;

    `include "tb_ref_model.svh"

    tetris_ai_top dut (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("ERROR %0t: %s", $time, reason);
        $display("Test failures found");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("%s is 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        rng = xorshift32(rng);
        return rng % n;
    endfunction

    // one classic cycle with the ack expected on the first edge after the request
    task automatic bus_cycle(input logic we, input logic [`WB_ADDR_W-1:0] adr,
                             input logic [`WB_DATA_W-1:0] wdata,
                             output logic [`WB_DATA_W-1:0] rdata);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        @(posedge clk);
        #1;
        if (wb_ack !== 1'b1) begin
            abort_run($sformatf("no ack one cycle after request to address %0d", adr));
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(posedge clk);
        #1;
    endtask

    task automatic write_reg(input logic [`WB_ADDR_W-1:0] adr, input logic [31:0] data);
        logic [31:0] unused_rd;
        bus_cycle(1'b1, adr, data, unused_rd);
    endtask

    task automatic read_reg(input logic [`WB_ADDR_W-1:0] adr, output logic [31:0] data);
        bus_cycle(1'b0, adr, '0, data);
    endtask

    task automatic load_board(input board_t b);
        logic [31:0] rd;
        for (int y = 0; y < `BOARD_ROWS; y++) begin
            write_reg(ADDR_ROW0 + 5'(y), 32'(b[y]));
        end
        for (int y = 0; y < `BOARD_ROWS; y++) begin
            read_reg(ADDR_ROW0 + 5'(y), rd);
            check_value($sformatf("board row %0d", y), rd, 32'(b[y]));
        end
        tb_board = b;
    endtask

    // column heights up to 12 keep the four top rows clear
    task automatic make_random_board(output board_t b);
        int h;
        b = '0;
        for (int c = 0; c < `BOARD_COLS; c++) begin
            h = int'(rand_below(13));
            for (int y = 0; y < h; y++) begin
                if (rand_below(8) != 0) begin
                    b[y][c] = 1'b1;
                end
            end
        end
    endtask

    task automatic start_search(input int kind);
        write_reg(ADDR_CTRL, (32'(kind) << CTRL_KIND_LSB) | 32'h1);
    endtask

    task automatic wait_done();
        logic [31:0] rd;
        int          polls;
        polls = 0;
        rd    = '0;
        while (rd[STATUS_DONE_BIT] !== 1'b1) begin
            if (polls == POLL_LIMIT) begin
                abort_run("done bit never set within the poll limit");
            end
            read_reg(ADDR_STATUS, rd);
            if (rd[STATUS_DONE_BIT] !== 1'b1) begin
                check_value("busy during search", 32'(rd[STATUS_BUSY_BIT]), 32'd1);
            end
            polls++;
        end
    endtask

    task automatic check_search(input int kind);
        logic [31:0] rd;
        bit          exp_found;
        int          exp_col;
        int          exp_rot;
        int          exp_lines;
        choose_move(tb_board, kind, exp_found, exp_col, exp_rot, exp_lines);
        read_reg(ADDR_STATUS, rd);
        check_value("status after search", rd, 32'h2);
        read_reg(ADDR_RESULT, rd);
        check_value("result found", 32'(rd[RESULT_FOUND_BIT]), 32'(exp_found));
        if (exp_found) begin
            check_value("result column", 32'(rd[RESULT_COL_LSB +: 4]), 32'(exp_col));
            check_value("result rotation", 32'(rd[RESULT_ROT_LSB +: 2]), 32'(exp_rot));
            check_value("best lines", 32'(dut.u_tracker.lines_q), 32'(exp_lines));
            check_value("best block type", 32'(dut.u_tracker.best_type_o),
                        32'((kind << 2) | exp_rot));
        end
        // kind register survives a start written while busy
        read_reg(ADDR_CTRL, rd);
        check_value("piece kind", 32'(rd[CTRL_KIND_LSB +: 3]), 32'(kind));
    endtask

    a_ack_pulse: assert property (@(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack)
        else abort_run("wb_ack_o stayed high for two cycles");

    a_ack_after_req: assert property (@(posedge clk) disable iff (rst)
        (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
        else abort_run("request was not acknowledged on the next cycle");

    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else abort_run("wb_ack_o rose without a request");

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        board_t      b;
        logic [31:0] rd;
        clk      = 1'b0;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        rng      = 32'hdf22_845a;
        tb_board = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        // idle state after reset
        read_reg(ADDR_STATUS, rd);
        check_value("status after reset", rd, 32'h0);
        read_reg(ADDR_RESULT, rd);
        check_value("found after reset", 32'(rd[RESULT_FOUND_BIT]), 32'h0);

        // I piece on an empty well
        load_board('0);
        start_search(0);
        wait_done();
        check_search(0);

        // bottom row with a gap in column 4
        b    = '0;
        b[0] = 10'h3ef;
        load_board(b);
        start_search(0);
        wait_done();
        check_search(0);
        read_reg(ADDR_RESULT, rd);
        check_value("line clearing column", 32'(rd[RESULT_COL_LSB +: 4]), 32'd4);

        // a start while busy is dropped and the next start clears done
        load_board('0);
        start_search(2);
        read_reg(ADDR_STATUS, rd);
        check_value("status during search", rd, 32'h1);
        start_search(5);
        wait_done();
        check_search(2);
        start_search(6);
        read_reg(ADDR_STATUS, rd);
        check_value("status after restart", rd, 32'h1);
        wait_done();
        check_search(6);

        for (int i = 0; i < RANDOM_BOARDS; i++) begin
            make_random_board(b);
            load_board(b);
            start_search(i % 7);
            wait_done();
            check_search(i % 7);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/tetris_ai_top.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "tetris_ai_settings.svh"

module tetris_ai_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [`WB_ADDR_W-1:0] wb_adr_i,
    input  logic [`WB_DATA_W-1:0] wb_dat_i,
    output logic [`WB_DATA_W-1:0] wb_dat_o,
    output logic                  wb_ack_o
);
    import board_pkg::*;

    board_t      board;
    piece_kind_t kind;
    logic        start;
    logic        clear;
    logic        finish;
    col_t        best_col;
    block_type_t best_type;
    logic        found;
    logic        search_done;

    candidate_if cand_bus ();

    wb_board_regs u_regs (
        .clk           (clk),
        .rst           (rst),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .board_o       (board),
        .kind_o        (kind),
        .start_o       (start),
        .best_col_i    (best_col),
        .best_type_i   (best_type),
        .found_i       (found),
        .search_done_i (search_done)
    );

    placement_search u_search (
        .clk      (clk),
        .rst      (rst),
        .start_i  (start),
        .board_i  (board),
        .kind_i   (kind),
        .cand     (cand_bus),
        .clear_o  (clear),
        .finish_o (finish)
    );

    best_move_tracker u_tracker (
        .clk         (clk),
        .rst         (rst),
        .clear_i     (clear),
        .cand        (cand_bus),
        .finish_i    (finish),
        .best_col_o  (best_col),
        .best_type_o (best_type),
        .found_o     (found),
        .done_o      (search_done)
    );

endmodule

`default_nettype wire

// ==== src/wb_board_regs.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "tetris_ai_settings.svh"

module wb_board_regs (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   wb_cyc_i,
    input  logic                   wb_stb_i,
    input  logic                   wb_we_i,
    input  logic [`WB_ADDR_W-1:0]  wb_adr_i,
    input  logic [`WB_DATA_W-1:0]  wb_dat_i,
    output logic [`WB_DATA_W-1:0]  wb_dat_o,
    output logic                   wb_ack_o,
    output board_pkg::board_t      board_o,
    output board_pkg::piece_kind_t kind_o,
    output logic                   start_o,
    input  board_pkg::col_t        best_col_i,
    input  board_pkg::block_type_t best_type_i,
    input  logic                   found_i,
    input  logic                   search_done_i
);
    import wb_map_pkg::*;

    logic                  req;
    logic                  wr;
    logic                  ctrl_wr;
    logic                  busy_q;
    logic                  done_q;
    logic [3:0]            row_idx;
    logic [`WB_DATA_W-1:0] rdata;

    // no new request during the ack cycle
    assign req     = wb_cyc_i & wb_stb_i & ~wb_ack_o;
    assign wr      = req & wb_we_i;
    // control writes are dropped while a search runs
    assign ctrl_wr = wr && (wb_adr_i == ADDR_CTRL) && !busy_q;
    assign row_idx = 4'(wb_adr_i - ADDR_ROW0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack_o <= 1'b0;
            start_o  <= 1'b0;
            busy_q   <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            wb_ack_o <= req;
            start_o  <= ctrl_wr & wb_dat_i[CTRL_START_BIT];
            if (ctrl_wr && wb_dat_i[CTRL_START_BIT]) begin
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end else if (search_done_i) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr && wb_adr_i <= ADDR_ROW15) begin
            board_o[row_idx] <= wb_dat_i[`BOARD_COLS-1:0];
        end
        if (ctrl_wr) begin
            kind_o <= wb_dat_i[CTRL_KIND_LSB +: $bits(kind_o)];
        end
        if (req) begin
            wb_dat_o <= rdata;
        end
    end

    // start bit always reads back as 0
    always_comb begin
        rdata = '0;
        if (wb_adr_i <= ADDR_ROW15) begin
            rdata[`BOARD_COLS-1:0] = board_o[row_idx];
        end else begin
            case (wb_adr_i)
                ADDR_CTRL: begin
                    rdata[CTRL_KIND_LSB +: $bits(kind_o)] = kind_o;
                end
                ADDR_STATUS: begin
                    rdata[STATUS_BUSY_BIT] = busy_q;
                    rdata[STATUS_DONE_BIT] = done_q;
                end
                ADDR_RESULT: begin
                    rdata[RESULT_COL_LSB +: $bits(best_col_i)] = best_col_i;
                    rdata[RESULT_ROT_LSB +: 2] = best_type_i[1:0];
                    rdata[RESULT_FOUND_BIT] = found_i;
                end
                default: ;
            endcase
        end
    end

    a_done_while_busy: assert property (@(posedge clk) disable iff (rst)
        search_done_i |-> busy_q);

endmodule

`default_nettype wire

// ==== src/best_move_tracker.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "tetris_ai_settings.svh"

module best_move_tracker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   clear_i,
    candidate_if.sink              cand,
    input  logic                   finish_i,
    output board_pkg::col_t        best_col_o,
    output board_pkg::block_type_t best_type_o,
    output logic                   found_o,
    output logic                   done_o
);
    import board_pkg::*;

    metric_t lines_q;
    metric_t bump_q;
    metric_t heights_q;
    metric_t holes_q;
    logic    last_seen_q;
    logic    win;

    // more lines first, then less bumpiness, lower heights, fewer holes
    always_comb begin
        if (cand.lines != lines_q) begin
            win = cand.lines > lines_q;
        end else if (cand.bumpiness != bump_q) begin
            win = cand.bumpiness < bump_q;
        end else if (cand.heights != heights_q) begin
            win = cand.heights < heights_q;
        end else begin
            win = cand.holes < holes_q;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lines_q     <= '0;
            bump_q      <= 8'd255;
            heights_q   <= 8'd255;
            holes_q     <= 8'd255;
            best_col_o  <= '0;
            best_type_o <= '0;
            found_o     <= 1'b0;
            last_seen_q <= 1'b0;
            done_o      <= 1'b0;
        end else begin
            // finish only counts when the last placement was skipped
            done_o <= (cand.valid & cand.last) | (finish_i & ~last_seen_q);
            if (clear_i) begin
                lines_q     <= '0;
                bump_q      <= 8'd255;
                heights_q   <= 8'd255;
                holes_q     <= 8'd255;
                found_o     <= 1'b0;
                last_seen_q <= 1'b0;
            end else if (cand.valid) begin
                if (cand.last) begin
                    last_seen_q <= 1'b1;
                end
                if (win) begin
                    lines_q     <= cand.lines;
                    bump_q      <= cand.bumpiness;
                    heights_q   <= cand.heights;
                    holes_q     <= cand.holes;
                    best_col_o  <= cand.col;
                    best_type_o <= cand.block_type;
                    found_o     <= 1'b1;
                end
            end
        end
    end

    // a stored move carries the height sum of a real board
    a_found_has_cand: assert property (@(posedge clk) disable iff (rst)
        found_o |-> (heights_q <= 8'(`BOARD_ROWS * `BOARD_COLS)));

endmodule

`default_nettype wire

// ==== src/placement_search.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "tetris_ai_settings.svh"

module placement_search (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_i,
    input  board_pkg::board_t      board_i,
    input  board_pkg::piece_kind_t kind_i,
    candidate_if.source            cand,
    output logic                   clear_o,
    output logic                   finish_o
);
    import board_pkg::*;

    localparam logic [3:0] TOP_ROW  = 4'(`BOARD_ROWS - 4);
    localparam col_t       LAST_COL = col_t'(`BOARD_COLS - 1);

    search_state_t state_q;
    rot_t          rot_q;
    col_t          col_q;
    // board row of the bottom of the shape box
    logic [3:0]    row_q;
    shape_t        shape;
    row_t [3:0]    shape_rows;
    logic          side_out;
    board_t        piece_now;
    board_t        piece_down;
    board_t        merged;
    logic          hit_now;
    logic          hit_down;
    logic          last_place;
    logic          advance;

    function automatic board_t place_rows(row_t [3:0] rows, logic [4:0] base);
        board_t b;
        b = '0;
        for (int r = 0; r < 4; r++) begin
            if (int'(base) + r < `BOARD_ROWS) begin
                b[int'(base) + r] = rows[r];
            end
        end
        return b;
    endfunction

    always_comb begin
        logic [`BOARD_COLS+3:0] wide;
        shape    = piece_shape(kind_i, rot_q);
        side_out = 1'b0;
        for (int r = 0; r < 4; r++) begin
            wide       = '0;
            wide[3:0]  = shape[r*4 +: 4];
            wide       = wide << col_q;
            shape_rows[r] = wide[`BOARD_COLS-1:0];
            // shape hangs over the right wall
            if (wide[`BOARD_COLS+3:`BOARD_COLS] != 4'h0) begin
                side_out = 1'b1;
            end
        end
        piece_now  = place_rows(shape_rows, {1'b0, row_q});
        piece_down = place_rows(shape_rows, {1'b0, row_q} - 5'd1);
        hit_now    = |(piece_now & board_i);
        hit_down   = (row_q == 4'd0) || (|(piece_down & board_i));
        merged     = board_i | piece_now;
        last_place = (rot_q == 2'd3) && (col_q == LAST_COL);
        advance    = (state_q == EMIT) || ((state_q == PLACE) && (side_out || hit_now));
    end

    board_features u_features (
        .board_i     (merged),
        .lines_o     (cand.lines),
        .bumpiness_o (cand.bumpiness),
        .heights_o   (cand.heights),
        .holes_o     (cand.holes)
    );

    assign cand.valid      = (state_q == EMIT);
    assign cand.last       = last_place;
    assign cand.col        = col_q;
    assign cand.block_type = {kind_i, rot_q};
    assign finish_o        = (state_q == FINISH);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q <= IDLE;
            rot_q   <= '0;
            col_q   <= '0;
            row_q   <= '0;
            clear_o <= 1'b0;
        end else begin
            clear_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        clear_o <= 1'b1;
                        rot_q   <= '0;
                        col_q   <= '0;
                        row_q   <= TOP_ROW;
                        state_q <= PLACE;
                    end
                end
                PLACE: begin
                    if (!(side_out || hit_now)) begin
                        state_q <= DROP;
                    end
                end
                DROP: begin
                    // one row per cycle until resting
                    if (hit_down) begin
                        state_q <= EMIT;
                    end else begin
                        row_q <= row_q - 4'd1;
                    end
                end
                FINISH: begin
                    state_q <= IDLE;
                end
                default: ;
            endcase
            // next column, then next rotation
            if (advance) begin
                row_q <= TOP_ROW;
                if (last_place) begin
                    state_q <= FINISH;
                end else begin
                    state_q <= PLACE;
                    if (col_q == LAST_COL) begin
                        col_q <= '0;
                        rot_q <= rot_q + 2'd1;
                    end else begin
                        col_q <= col_q + 4'd1;
                    end
                end
            end
        end
    end

    // an emitted piece rests inside the well without overlap
    a_cand_fits: assert property (@(posedge clk) disable iff (rst)
        cand.valid |-> (hit_down && !hit_now && !side_out));

endmodule

`default_nettype wire

// ==== src/board_features.sv ====
`default_nettype none
`timescale 1ns/100ps
`include "tetris_ai_settings.svh"

module board_features (
    input  board_pkg::board_t  board_i,
    output board_pkg::metric_t lines_o,
    output board_pkg::metric_t bumpiness_o,
    output board_pkg::metric_t heights_o,
    output board_pkg::metric_t holes_o
);
    import board_pkg::*;

    always_comb begin
        metric_t lines;
        metric_t bump;
        metric_t sum_h;
        metric_t holes;
        metric_t h [`BOARD_COLS];
        lines = '0;
        bump  = '0;
        sum_h = '0;
        holes = '0;
        for (int y = 0; y < `BOARD_ROWS; y++) begin
            if (&board_i[y]) begin
                lines = lines + 8'd1;
            end
        end
        for (int c = 0; c < `BOARD_COLS; c++) begin
            // highest filled row plus one
            h[c] = '0;
            for (int y = 0; y < `BOARD_ROWS; y++) begin
                if (board_i[y][c]) begin
                    h[c] = metric_t'(y + 1);
                end
            end
            sum_h = sum_h + h[c];
            // empty cells under the column top
            for (int y = 0; y < `BOARD_ROWS; y++) begin
                if (!board_i[y][c] && metric_t'(y) < h[c]) begin
                    holes = holes + 8'd1;
                end
            end
        end
        for (int c = 1; c < `BOARD_COLS; c++) begin
            if (h[c] > h[c-1]) begin
                bump = bump + (h[c] - h[c-1]);
            end else begin
                bump = bump + (h[c-1] - h[c]);
            end
        end
        lines_o     = lines;
        bumpiness_o = bump;
        heights_o   = sum_h;
        holes_o     = holes;
    end

endmodule

`default_nettype wire

// ==== src/candidate_if.sv ====
`default_nettype none
`timescale 1ns/100ps

interface candidate_if;
    import board_pkg::*;

    logic        valid;
    // final placement of the search
    logic        last;
    col_t        col;
    block_type_t block_type;
    metric_t     lines;
    metric_t     bumpiness;
    metric_t     heights;
    metric_t     holes;

    modport source (
        output valid, last, col, block_type, lines, bumpiness, heights, holes
    );

    modport sink (
        input valid, last, col, block_type, lines, bumpiness, heights, holes
    );

endinterface

`default_nettype wire

// ==== src/wb_map_pkg.sv ====
`default_nettype none
`include "tetris_ai_settings.svh"

package wb_map_pkg;

    // word addresses
    localparam logic [`WB_ADDR_W-1:0] ADDR_ROW0   = 5'd0;
    localparam logic [`WB_ADDR_W-1:0] ADDR_ROW15  = 5'd15;
    localparam logic [`WB_ADDR_W-1:0] ADDR_CTRL   = 5'd16;
    localparam logic [`WB_ADDR_W-1:0] ADDR_STATUS = 5'd17;
    localparam logic [`WB_ADDR_W-1:0] ADDR_RESULT = 5'd18;

    // control word
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_KIND_LSB  = 1;

    // status word
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

    // result word
    localparam int RESULT_COL_LSB   = 0;
    localparam int RESULT_ROT_LSB   = 4;
    localparam int RESULT_FOUND_BIT = 6;

endpackage

`default_nettype wire

// ==== src/board_pkg.sv ====
`default_nettype none
`include "tetris_ai_settings.svh"

package board_pkg;

    typedef logic [`BOARD_COLS-1:0] row_t;
    // row 0 is the bottom of the well
    typedef row_t [`BOARD_ROWS-1:0] board_t;
    typedef logic [3:0] col_t;
    // I, O, T, S, Z, J, L
    typedef logic [2:0] piece_kind_t;
    typedef logic [1:0] rot_t;
    // kind in bits 4:2, rotation in bits 1:0
    typedef logic [4:0] block_type_t;
    typedef logic [7:0] metric_t;
    // bit 4*r + c, r counted up from the bottom of the shape
    typedef logic [15:0] shape_t;

    typedef enum logic [2:0] {
        IDLE,
        PLACE,
        DROP,
        EMIT,
        FINISH
    } search_state_t;

    function automatic shape_t piece_shape(piece_kind_t kind, rot_t rot);
        shape_t s;
        shape_t t;
        case (kind)
            3'd1: s = 16'h0033;
            3'd2: s = 16'h0027;
            3'd3: s = 16'h0063;
            3'd4: s = 16'h0036;
            3'd5: s = 16'h0017;
            3'd6: s = 16'h0047;
            default: s = 16'h000f;
        endcase
        // quarter turns inside the 4x4 box
        for (int i = 0; i < 3; i++) begin
            if (i < int'(rot)) begin
                t = '0;
                for (int r = 0; r < 4; r++) begin
                    for (int c = 0; c < 4; c++) begin
                        t[r*4 + c] = s[c*4 + 3 - r];
                    end
                end
                s = t;
            end
        end
        // settle into the bottom left corner
        for (int i = 0; i < 3; i++) begin
            if (s[3:0] == 4'h0) begin
                s = s >> 4;
            end
            if ((s & 16'h1111) == 16'h0000) begin
                s = s >> 1;
            end
        end
        return s;
    endfunction

endpackage

`default_nettype wire

// ==== src/tetris_ai_settings.svh ====
`ifndef TETRIS_AI_SETTINGS_SVH
`define TETRIS_AI_SETTINGS_SVH

// playfield size, row 0 at the bottom
`define BOARD_ROWS 16
`define BOARD_COLS 10

// wishbone word address and data widths
`define WB_ADDR_W 5
`define WB_DATA_W 32

`endif
